//--- build.f
+incdir+hw
hw/core_pkg.sv
hw/ctrl_cmd_proc.sv
hw/core_settings_regs.sv
hw/core_status_readback.sv
hw/pps_source_select.sv
hw/b200_core_ctrl.sv
verif/core_asserts.sv
verif/core_tb.sv

//--- Makefile
# Verilator flow for the control core

VERILATOR  ?= verilator
TOP        := core_tb
RTL_TOP    := b200_core_ctrl
FILELIST   := build.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_MSG   := Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/core_tb.sv
// control core testbench
`timescale 1ns/1ps
`include "core_macros.svh"

module core_tb
    import core_pkg::*;
();

    localparam int CLK_HALF_NS     = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_CMDS        = 32;
    localparam int BP_CMDS         = 16;
    localparam int PPS_CHECK_CYC   = 64;
    // 200 cycles per command plus 5 pps periods
    localparam int WATCHDOG_CYCLES = NUM_CMDS * 200 + 5 * `PPS_PERIOD_CYCLES + RESET_CYCLES;
    localparam set_addr_t UNUSED_ADDR = 8'd77;

    logic       radio_clk;
    logic       bus_rst;
    ctrl_word_t i_ctrl_tdata;
    logic       i_ctrl_tvalid;
    logic       i_resp_tready = 1'b1;
    logic       i_pps_int;
    logic       i_pps_ext;
    lock_t      i_lock_signals;
    set_data_t  i_rb_misc;
    logic       o_ctrl_tready;
    rb_word_t   o_resp_tdata;
    logic       o_resp_tvalid;
    set_data_t  o_misc_outs;
    logic       o_time_sync;
    logic       o_pps;

    integer     seed;
    rb_word_t   exp_q[$];

    // register model
    set_data_t    m_misc;
    rb_sel_t      m_rb_sel;
    status_byte_t m_gpsdo;
    pps_sel_e     m_pps_sel;
    logic         m_time_sync;

    // response back-pressure pattern
    logic       bp_en;
    logic       bp_pattern [0:255];
    logic [7:0] bp_idx = 8'd0;

    initial radio_clk = 1'b0;
    always #CLK_HALF_NS radio_clk = ~radio_clk;

    b200_core_ctrl dut (
        .radio_clk      (radio_clk),
        .bus_rst        (bus_rst),
        .i_ctrl_tdata   (i_ctrl_tdata),
        .i_ctrl_tvalid  (i_ctrl_tvalid),
        .o_ctrl_tready  (o_ctrl_tready),
        .o_resp_tdata   (o_resp_tdata),
        .o_resp_tvalid  (o_resp_tvalid),
        .i_resp_tready  (i_resp_tready),
        .i_pps_int      (i_pps_int),
        .i_pps_ext      (i_pps_ext),
        .i_lock_signals (i_lock_signals),
        .i_rb_misc      (i_rb_misc),
        .o_misc_outs    (o_misc_outs),
        .o_time_sync    (o_time_sync),
        .o_pps          (o_pps)
    );

    ////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////

    task automatic abort_run;
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // expected response word built field by field from the slot layout
    function automatic rb_word_t expected_readback(input rb_sel_t slot,
                                                   input lock_t lock,
                                                   input set_data_t rb_misc);
        rb_word_t word;
        word = '0;
        case (slot)
            2'd0: begin
                word[63:32] = `RB_SIGNATURE;
                word[31:16] = `COMPAT_MAJOR;
                word[15:0]  = `COMPAT_MINOR;
            end
            2'd1: begin
                word[47:40] = `RADIO_ST;
                word[39:32] = m_gpsdo;
                word[31:0]  = rb_misc;
            end
            2'd2: word[1:0] = lock;
            default: begin
                word[34:33] = m_pps_sel;
                word[32]    = m_time_sync;
                word[31:0]  = m_misc;
            end
        endcase
        return word;
    endfunction

    task automatic model_write(input set_addr_t addr, input set_data_t data);
        case (addr)
            `SR_CORE_MISC:     m_misc = data;
            `SR_CORE_READBACK: m_rb_sel = data[1:0];
            `SR_CORE_GPSDO_ST: m_gpsdo = data[7:0];
            `SR_CORE_SYNC: begin
                m_pps_sel   = pps_sel_e'(data[1:0]);
                m_time_sync = data[2];
            end
            default: ;
        endcase
    endtask

    // one command beat that returns on the accepting edge
    task automatic send_cmd(input set_addr_t addr, input set_data_t data);
        logic [23:0] junk;
        junk = 24'($random(seed));
        @(posedge radio_clk);
        // upper bits are don't care and get noise
        i_ctrl_tdata  <= {junk, addr, data};
        i_ctrl_tvalid <= 1'b1;
        @(posedge radio_clk);
        while (!o_ctrl_tready) begin
            @(posedge radio_clk);
        end
        i_ctrl_tvalid <= 1'b0;
        model_write(addr, data);
        exp_q.push_back(expected_readback(m_rb_sel, i_lock_signals, i_rb_misc));
    endtask

    task automatic wait_responses;
        @(negedge radio_clk);
        while (exp_q.size() != 0) begin
            @(negedge radio_clk);
        end
    endtask

    task automatic send_and_wait(input set_addr_t addr, input set_data_t data);
        send_cmd(addr, data);
        wait_responses();
    endtask

    // o_pps against i_pps_ext sampled two edges back
    task automatic check_ext_pps;
        logic d1;
        logic d2;
        d1 = 1'b0;
        d2 = 1'b0;
        for (int n = 0; n < PPS_CHECK_CYC; n++) begin
            @(posedge radio_clk);
            if (n >= 2) begin
                check_value("o_pps", o_pps, d2);
            end
            d2 = d1;
            d1 = i_pps_ext;
            i_pps_ext <= 1'($random(seed));
        end
        i_pps_ext <= 1'b0;
    endtask

    task automatic check_no_pps;
        for (int n = 0; n < PPS_CHECK_CYC; n++) begin
            @(posedge radio_clk);
            check_value("o_pps", o_pps, 0);
            i_pps_ext <= 1'($random(seed));
            i_pps_int <= 1'($random(seed));
        end
        i_pps_ext <= 1'b0;
        i_pps_int <= 1'b0;
    endtask

    // first rise may come from the source switch so periods start at the second
    task automatic check_internal_pps;
        int   rise_at [0:3];
        int   found;
        int   cyc;
        logic prev;
        found = 0;
        cyc   = 0;
        prev  = o_pps;
        while (found < 4) begin
            @(posedge radio_clk);
            cyc++;
            if (o_pps && !prev) begin
                rise_at[found] = cyc;
                found++;
            end
            prev = o_pps;
        end
        check_value("pps period", rise_at[2] - rise_at[1], `PPS_PERIOD_CYCLES);
        check_value("pps period", rise_at[3] - rise_at[2], `PPS_PERIOD_CYCLES);
    endtask

    ////////////////////////////////////////////////////////////////////
    // response side
    ////////////////////////////////////////////////////////////////////

    always @(posedge radio_clk) begin
        if (bp_en) begin
            i_resp_tready <= bp_pattern[bp_idx];
            bp_idx        <= bp_idx + 8'd1;
        end else begin
            i_resp_tready <= 1'b1;
        end
    end

    // compare each response in order on transfer
    always @(posedge radio_clk) begin
        if (!bus_rst && o_resp_tvalid && i_resp_tready) begin
            if (exp_q.size() == 0) begin
                $display("Response arrived with no command pending");
                abort_run();
            end else begin
                check_value("o_resp_tdata", o_resp_tdata, exp_q.pop_front());
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge radio_clk);
        $display("Watchdog expired before the tests finished");
        abort_run();
    end

    ////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////

    initial begin
        seed           = 32'hab73400d;
        bus_rst        = 1'b1;
        i_ctrl_tdata   = '0;
        i_ctrl_tvalid  = 1'b0;
        i_pps_int      = 1'b0;
        i_pps_ext      = 1'b0;
        i_lock_signals = '0;
        i_rb_misc      = '0;
        bp_en          = 1'b0;
        m_misc         = '0;
        m_rb_sel       = '0;
        m_gpsdo        = '0;
        m_pps_sel      = PPS_GPSDO;
        m_time_sync    = 1'b0;
        for (int i = 0; i < 256; i++) begin
            bp_pattern[i] = (($random(seed) & 3) != 0);
        end
        repeat (RESET_CYCLES) @(posedge radio_clk);
        bus_rst <= 1'b0;
        @(negedge radio_clk);
        check_value("o_ctrl_tready", o_ctrl_tready, 1);
        check_value("o_resp_tvalid", o_resp_tvalid, 0);

        // signature slot via the select write itself
        send_and_wait(`SR_CORE_READBACK, 32'd0);

        // misc register then unused address against the echo slot
        send_and_wait(`SR_CORE_READBACK, 32'd3);
        send_and_wait(`SR_CORE_MISC, $random(seed));
        check_value("o_misc_outs", o_misc_outs, m_misc);
        send_and_wait(UNUSED_ADDR, $random(seed));
        check_value("o_misc_outs", o_misc_outs, m_misc);
        check_value("o_time_sync", o_time_sync, 0);

        // status slot and lock slot
        send_and_wait(`SR_CORE_GPSDO_ST, $random(seed));
        @(posedge radio_clk);
        i_rb_misc <= $random(seed);
        send_and_wait(`SR_CORE_READBACK, 32'd1);
        for (int i = 1; i < 4; i++) begin
            @(posedge radio_clk);
            i_lock_signals <= lock_t'(i);
            repeat (4) @(posedge radio_clk);
            send_and_wait(`SR_CORE_READBACK, 32'd2);
        end

        // mixed commands under random back-pressure
        bp_en = 1'b1;
        for (int i = 0; i < BP_CMDS; i++) begin
            case ($random(seed) & 3)
                0:       send_cmd(`SR_CORE_MISC, $random(seed));
                1:       send_cmd(`SR_CORE_GPSDO_ST, $random(seed));
                2:       send_cmd(`SR_CORE_READBACK, $random(seed) & 3);
                default: send_cmd(UNUSED_ADDR, $random(seed));
            endcase
        end
        wait_responses();
        // no stray response left behind the last one
        check_value("o_resp_tvalid", o_resp_tvalid, 0);
        bp_en = 1'b0;

        // pps sources with responses echoing the sync register
        send_and_wait(`SR_CORE_READBACK, 32'd3);
        send_and_wait(`SR_CORE_SYNC, 32'd1);
        check_ext_pps();
        send_and_wait(`SR_CORE_SYNC, 32'd3);
        check_no_pps();
        // internal pps with time sync bit
        send_and_wait(`SR_CORE_SYNC, 32'd6);
        check_value("o_time_sync", o_time_sync, 1);
        check_internal_pps();

        repeat (4) @(posedge radio_clk);
        $display("Test passed");
        $finish;
    end

endmodule

//--- verif/core_asserts.sv
// command processor assertions
`timescale 1ns/1ps

module core_asserts
    import core_pkg::*;
(
    input logic       radio_clk,
    input logic       bus_rst,
    input ctrl_word_t i_ctrl_tdata,
    input logic       i_ctrl_tvalid,
    input logic       o_ctrl_tready,
    input rb_word_t   o_resp_tdata,
    input logic       o_resp_tvalid,
    input logic       i_resp_tready,
    input logic       o_set_stb
);

    // host keeps a command until taken
    a_ctrl_hold: assert property (@(posedge radio_clk) disable iff (bus_rst)
        (i_ctrl_tvalid && !o_ctrl_tready) |=> (i_ctrl_tvalid && $stable(i_ctrl_tdata)))
        else $error("command valid or data changed before ready");

    // response held under back-pressure
    a_resp_hold: assert property (@(posedge radio_clk) disable iff (bus_rst)
        (o_resp_tvalid && !i_resp_tready) |=> (o_resp_tvalid && $stable(o_resp_tdata)))
        else $error("response valid or data changed before ready");

    // one strobe cycle per command
    a_stb_single: assert property (@(posedge radio_clk) disable iff (bus_rst)
        o_set_stb |=> !o_set_stb)
        else $error("settings strobe longer than one cycle");

    // no new command while a response waits
    a_busy: assert property (@(posedge radio_clk) disable iff (bus_rst)
        o_resp_tvalid |-> !o_ctrl_tready)
        else $error("command ready while response pending");

endmodule

bind ctrl_cmd_proc core_asserts u_asserts (
    .radio_clk     (radio_clk),
    .bus_rst       (bus_rst),
    .i_ctrl_tdata  (i_ctrl_tdata),
    .i_ctrl_tvalid (i_ctrl_tvalid),
    .o_ctrl_tready (o_ctrl_tready),
    .o_resp_tdata  (o_resp_tdata),
    .o_resp_tvalid (o_resp_tvalid),
    .i_resp_tready (i_resp_tready),
    .o_set_stb     (o_set_stb)
);

//--- hw/b200_core_ctrl.sv
// radio board control core
`timescale 1ns/1ps

module b200_core_ctrl
    import core_pkg::*;
(
    input  logic       radio_clk,
    input  logic       bus_rst,
    // host command stream
    input  ctrl_word_t i_ctrl_tdata,
    input  logic       i_ctrl_tvalid,
    output logic       o_ctrl_tready,
    // host response stream
    output rb_word_t   o_resp_tdata,
    output logic       o_resp_tvalid,
    input  logic       i_resp_tready,
    // pps inputs
    input  logic       i_pps_int,
    input  logic       i_pps_ext,
    // board status
    input  lock_t      i_lock_signals,
    input  set_data_t  i_rb_misc,
    // board controls
    output set_data_t  o_misc_outs,
    output logic       o_time_sync,
    output logic       o_pps
);

    // settings bus
    logic         set_stb;
    set_addr_t    set_addr;
    set_data_t    set_data;

    // register file to readback
    rb_word_t     rb_data;
    rb_sel_t      rb_sel;
    status_byte_t gpsdo_st;
    pps_sel_e     pps_sel;

    //////////////////////////////////////////////////////////////////////
    // command processing
    //////////////////////////////////////////////////////////////////////

    ctrl_cmd_proc u_cmd_proc (
        .radio_clk     (radio_clk),
        .bus_rst       (bus_rst),
        .i_ctrl_tdata  (i_ctrl_tdata),
        .i_ctrl_tvalid (i_ctrl_tvalid),
        .o_ctrl_tready (o_ctrl_tready),
        .o_resp_tdata  (o_resp_tdata),
        .o_resp_tvalid (o_resp_tvalid),
        .i_resp_tready (i_resp_tready),
        .i_rb_data     (rb_data),
        .o_set_stb     (set_stb),
        .o_set_addr    (set_addr),
        .o_set_data    (set_data)
    );

    //////////////////////////////////////////////////////////////////////
    // setting registers
    //////////////////////////////////////////////////////////////////////

    core_settings_regs u_settings (
        .radio_clk   (radio_clk),
        .bus_rst     (bus_rst),
        .i_set_stb   (set_stb),
        .i_set_addr  (set_addr),
        .i_set_data  (set_data),
        .o_misc_outs (o_misc_outs),
        .o_rb_sel    (rb_sel),
        .o_gpsdo_st  (gpsdo_st),
        .o_time_sync (o_time_sync),
        .o_pps_sel   (pps_sel)
    );

    //////////////////////////////////////////////////////////////////////
    // readback
    //////////////////////////////////////////////////////////////////////

    core_status_readback u_readback (
        .radio_clk      (radio_clk),
        .bus_rst        (bus_rst),
        .i_lock_signals (i_lock_signals),
        .i_rb_misc      (i_rb_misc),
        .i_rb_sel       (rb_sel),
        .i_gpsdo_st     (gpsdo_st),
        .i_misc_outs    (o_misc_outs),
        .i_pps_sel      (pps_sel),
        .i_time_sync    (o_time_sync),
        .o_rb_data      (rb_data)
    );

    //////////////////////////////////////////////////////////////////////
    // pps
    //////////////////////////////////////////////////////////////////////

    pps_source_select u_pps (
        .radio_clk (radio_clk),
        .bus_rst   (bus_rst),
        .i_pps_int (i_pps_int),
        .i_pps_ext (i_pps_ext),
        .i_pps_sel (pps_sel),
        .o_pps     (o_pps)
    );

endmodule

//--- hw/pps_source_select.sv
// pps generator and source mux
`timescale 1ns/1ps
`include "core_macros.svh"

module pps_source_select
    import core_pkg::*;
(
    input  logic     radio_clk,
    input  logic     bus_rst,
    // gpsdo and external pps, both async
    input  logic     i_pps_int,
    input  logic     i_pps_ext,
    input  pps_sel_e i_pps_sel,
    output logic     o_pps
);

    localparam int unsigned PPS_CNT_W       = $clog2(`PPS_PERIOD_CYCLES);
    localparam int unsigned PPS_HIGH_CYCLES = `PPS_PERIOD_CYCLES / 4;

    logic [PPS_CNT_W-1:0] pps_cnt;
    logic                 gen_pps;
    logic [1:0]           gpsdo_pps_del;
    logic [1:0]           ext_pps_del;
    logic [1:0]           gen_pps_del;

    //////////////////////////////////////////////////////////////////////
    // internal pps generator
    //////////////////////////////////////////////////////////////////////

    // free running period counter
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            pps_cnt <= '0;
        end else if (pps_cnt == PPS_CNT_W'(`PPS_PERIOD_CYCLES - 1)) begin
            pps_cnt <= '0;
        end else begin
            pps_cnt <= pps_cnt + 1'b1;
        end
    end

    // high for first quarter of the period
    assign gen_pps = (pps_cnt < PPS_CNT_W'(PPS_HIGH_CYCLES));

    //////////////////////////////////////////////////////////////////////
    // input stages
    //////////////////////////////////////////////////////////////////////

    // internal pulse goes through the same two stages, equal lag on all
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            gpsdo_pps_del <= '0;
            ext_pps_del   <= '0;
            gen_pps_del   <= '0;
        end else begin
            gpsdo_pps_del <= {gpsdo_pps_del[0], i_pps_int};
            ext_pps_del   <= {ext_pps_del[0], i_pps_ext};
            gen_pps_del   <= {gen_pps_del[0], gen_pps};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // source mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (i_pps_sel)
            PPS_GPSDO:    o_pps = gpsdo_pps_del[1];
            PPS_EXT:      o_pps = ext_pps_del[1];
            PPS_INTERNAL: o_pps = gen_pps_del[1];
            default:      o_pps = 1'b0;
        endcase
    end

endmodule

//--- hw/core_status_readback.sv
// lock sync and readback select
`timescale 1ns/1ps
`include "core_macros.svh"

module core_status_readback
    import core_pkg::*;
(
    input  logic         radio_clk,
    input  logic         bus_rst,
    input  lock_t        i_lock_signals,
    input  set_data_t    i_rb_misc,
    input  rb_sel_t      i_rb_sel,
    input  status_byte_t i_gpsdo_st,
    input  set_data_t    i_misc_outs,
    input  pps_sel_e     i_pps_sel,
    input  logic         i_time_sync,
    output rb_word_t     o_rb_data
);

    // two flop stages, lock inputs are async
    lock_t lock_meta;
    lock_t lock_sync;

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            lock_meta <= '0;
            lock_sync <= '0;
        end else begin
            lock_meta <= i_lock_signals;
            lock_sync <= lock_meta;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // readback mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (i_rb_sel)
            // signature and compat
            2'd0: o_rb_data = {`RB_SIGNATURE, `COMPAT_MAJOR, `COMPAT_MINOR};
            // radio and gpsdo status plus board misc
            2'd1: o_rb_data = {16'h0000, `RADIO_ST, i_gpsdo_st, i_rb_misc};
            // front-end lock pair
            2'd2: o_rb_data = {62'd0, lock_sync};
            // settings echo
            2'd3: o_rb_data = {29'd0, i_pps_sel, i_time_sync, i_misc_outs};
            default: o_rb_data = '0;
        endcase
    end

endmodule

//--- hw/core_settings_regs.sv
// core setting registers
`timescale 1ns/1ps
`include "core_macros.svh"

module core_settings_regs
    import core_pkg::*;
(
    input  logic         radio_clk,
    input  logic         bus_rst,
    // settings bus
    input  logic         i_set_stb,
    input  set_addr_t    i_set_addr,
    input  set_data_t    i_set_data,
    // register outputs
    output set_data_t    o_misc_outs,
    output rb_sel_t      o_rb_sel,
    output status_byte_t o_gpsdo_st,
    output logic         o_time_sync,
    output pps_sel_e     o_pps_sel
);

    // address decode
    logic hit_misc;
    logic hit_rb;
    logic hit_gpsdo;
    logic hit_sync;

    assign hit_misc  = i_set_stb && (i_set_addr == `SR_CORE_MISC);
    assign hit_rb    = i_set_stb && (i_set_addr == `SR_CORE_READBACK);
    assign hit_gpsdo = i_set_stb && (i_set_addr == `SR_CORE_GPSDO_ST);
    assign hit_sync  = i_set_stb && (i_set_addr == `SR_CORE_SYNC);

    //////////////////////////////////////////////////////////////////////
    // misc outputs
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_misc_outs <= '0;
        end else if (hit_misc) begin
            o_misc_outs <= i_set_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // readback select
    //////////////////////////////////////////////////////////////////////

    // slot number in bits 1:0
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_rb_sel <= '0;
        end else if (hit_rb) begin
            o_rb_sel <= i_set_data[1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // gpsdo status
    //////////////////////////////////////////////////////////////////////

    // host view of the gpsdo, survives a core reset
    always_ff @(posedge radio_clk) begin
        if (hit_gpsdo) begin
            o_gpsdo_st <= i_set_data[7:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // time sync and pps source
    //////////////////////////////////////////////////////////////////////

    // bits 1:0 pps source, bit 2 time sync
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_pps_sel   <= PPS_GPSDO;
            o_time_sync <= 1'b0;
        end else if (hit_sync) begin
            o_pps_sel   <= pps_sel_e'(i_set_data[1:0]);
            o_time_sync <= i_set_data[2];
        end
    end

endmodule

//--- hw/ctrl_cmd_proc.sv
// control command processor
`timescale 1ns/1ps

module ctrl_cmd_proc
    import core_pkg::*;
(
    input  logic       radio_clk,
    input  logic       bus_rst,
    // command stream from host
    input  ctrl_word_t i_ctrl_tdata,
    input  logic       i_ctrl_tvalid,
    output logic       o_ctrl_tready,
    // response stream to host
    output rb_word_t   o_resp_tdata,
    output logic       o_resp_tvalid,
    input  logic       i_resp_tready,
    // selected readback source
    input  rb_word_t   i_rb_data,
    // settings bus
    output logic       o_set_stb,
    output set_addr_t  o_set_addr,
    output set_data_t  o_set_data
);

    cmd_state_e state;
    set_addr_t  cmd_addr;
    set_data_t  cmd_data;
    rb_word_t   resp_data;
    logic       resp_valid;
    logic       cmd_accept;
    logic       resp_done;

    //////////////////////////////////////////////////////////////////////
    // handshakes
    //////////////////////////////////////////////////////////////////////

    // only idle takes a command, one in flight
    assign o_ctrl_tready = (state == IDLE);
    assign cmd_accept    = i_ctrl_tvalid && o_ctrl_tready;
    assign resp_done     = resp_valid && i_resp_tready;

    //////////////////////////////////////////////////////////////////////
    // command FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_accept) begin
                        state <= WRITE;
                    end
                end
                // strobe goes out this cycle
                WRITE: begin
                    state <= RESPOND;
                end
                // first cycle captures, then hold until host takes it
                RESPOND: begin
                    if (!resp_valid) begin
                        resp_valid <= 1'b1;
                    end else if (resp_done) begin
                        resp_valid <= 1'b0;
                        state      <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // latch address and data of the accepted word, upper bits dropped
    always_ff @(posedge radio_clk) begin
        if (cmd_accept) begin
            cmd_addr <= i_ctrl_tdata[39:32];
            cmd_data <= i_ctrl_tdata[31:0];
        end
    end

    // readback already shows the write by now
    always_ff @(posedge radio_clk) begin
        if ((state == RESPOND) && !resp_valid) begin
            resp_data <= i_rb_data;
        end
    end

    // settings bus, one strobe per command
    assign o_set_stb  = (state == WRITE);
    assign o_set_addr = cmd_addr;
    assign o_set_data = cmd_data;

    assign o_resp_tdata  = resp_data;
    assign o_resp_tvalid = resp_valid;

endmodule

//--- hw/core_pkg.sv
// control core types
package core_pkg;

    // host command and response words
    typedef logic [63:0] ctrl_word_t;
    typedef logic [63:0] rb_word_t;

    // settings bus fields
    typedef logic [7:0]  set_addr_t;
    typedef logic [31:0] set_data_t;

    // status and readback fields
    typedef logic [7:0]  status_byte_t;
    typedef logic [1:0]  lock_t;
    typedef logic [1:0]  rb_sel_t;

    // pps source, encoding matches sync register bits 1:0
    typedef enum logic [1:0] {
        PPS_GPSDO    = 2'd0,
        PPS_EXT      = 2'd1,
        PPS_INTERNAL = 2'd2,
        PPS_NONE     = 2'd3
    } pps_sel_e;

    // command processor FSM
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        RESPOND
    } cmd_state_e;

endpackage

//--- hw/core_macros.svh
// control core constants
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// settings bus register map
//////////////////////////////////////////////////////////////////////

// one word per register
`define SR_CORE_MISC      8'd16
`define SR_CORE_READBACK  8'd32
`define SR_CORE_GPSDO_ST  8'd40
`define SR_CORE_SYNC      8'd48

//////////////////////////////////////////////////////////////////////
// readback constants
//////////////////////////////////////////////////////////////////////

`define COMPAT_MAJOR      16'h0010
`define COMPAT_MINOR      16'h0000
`define RB_SIGNATURE      32'hACE0BA5E
// fixed radio status, both channels fitted
`define RADIO_ST          8'h02

// internal pps period in radio_clk cycles
`define PPS_PERIOD_CYCLES 1000

`endif
